// ==== common/rv32Pkg.sv ====
package rv32Pkg;

	typedef logic [31:0] dataWord;
	typedef logic [4:0] regIndex;
	typedef logic [3:0] byteMask;
	// Bit 1 address misaligned, bit 0 invalid instruction
	typedef logic [1:0] errorCode;

	typedef enum logic [1:0] {
		stateHalt = 2'b00,
		stateFetch = 2'b10,
		stateExecute = 2'b11
	} coreState;

	typedef enum logic [1:0] {
		phaseIdle,
		phaseFetch,
		phaseLoad,
		phaseStore
	} memPhase;

	typedef enum logic [3:0] {
		classLui,
		classAuipc,
		classJal,
		classJalr,
		classBranch,
		classLoad,
		classStore,
		classAluImm,
		classAlu,
		classFence,
		classInvalid
	} instrClass;

	typedef struct packed {
		instrClass kind;
		regIndex rd;
		regIndex rs1;
		regIndex rs2;
		logic [2:0] funct3;
		logic alt;
		dataWord imm;
	} decodedInstr;

	typedef struct packed {
		dataWord address;
		byteMask byteSelect;
		dataWord writeData;
		logic readEnable;
		logic writeEnable;
	} memRequest;

	typedef struct packed {
		logic run;
		logic writeEnable;
		byteMask byteSelect;
		logic [15:0] address;
		dataWord writeData;
	} mgmtRequest;

	localparam logic [1:0] mgmtAddressSystem = 2'b00;
	localparam logic [1:0] mgmtAddressRegisters = 2'b01;

	// Sub-offsets within the program counter block
	localparam logic [3:0] mgmtPcSet = 4'h0;
	localparam logic [3:0] mgmtPcJump = 4'h4;
	localparam logic [3:0] mgmtPcStep = 4'h8;

	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opAluImm = 7'b0010011;
	localparam logic [6:0] opAlu = 7'b0110011;
	localparam logic [6:0] opFence = 7'b0001111;

	function automatic logic mgmtIsPc(input logic [15:0] address);
		return address[15:14] == mgmtAddressSystem && address[13:4] == 10'h000;
	endfunction

	function automatic logic mgmtIsInstruction(input logic [15:0] address);
		return address[15:14] == mgmtAddressSystem && address[13:4] == 10'h001;
	endfunction

	function automatic logic mgmtIsClearError(input logic [15:0] address);
		return address[15:14] == mgmtAddressSystem && address[13:4] == 10'h002;
	endfunction

	function automatic logic mgmtIsRegister(input logic [15:0] address);
		return address[15:14] == mgmtAddressRegisters && address[13:7] == 7'h00;
	endfunction

	// Zero every byte lane whose select bit is low
	function automatic dataWord maskBytes(input dataWord value, input byteMask mask);
		dataWord masked;
		for (int i = 0; i < 4; i++)
			masked[8 * i +: 8] = mask[i] ? value[8 * i +: 8] : 8'h00;
		return masked;
	endfunction

endpackage

// ==== verilog/registerFile.sv ====
module registerFile
	import rv32Pkg::*;
(
	input logic clk,
	input mgmtRequest mgmt,
	input coreState state,
	input decodedInstr instr,
	input logic writeBack,
	input dataWord writeData,
	output dataWord rs1Value,
	output dataWord rs2Value,
	output dataWord mgmtValue
);

	dataWord registers [1:31];
	regIndex mgmtIndex;
	logic mgmtRegisterWrite;

	assign mgmtIndex = mgmt.address[6:2];
	assign mgmtRegisterWrite = !mgmt.run && mgmt.writeEnable && state == stateHalt
		&& mgmtIsRegister(mgmt.address) && mgmtIndex != '0;

	// Core writes only in execute and management only in halt
	always_ff @(posedge clk) begin
		if (writeBack)
			registers[instr.rd] <= writeData;
		else if (mgmtRegisterWrite)
			registers[mgmtIndex] <= mgmt.writeData;
	end

	assign rs1Value = instr.rs1 != '0 ? registers[instr.rs1] : '0;
	assign rs2Value = instr.rs2 != '0 ? registers[instr.rs2] : '0;
	assign mgmtValue = mgmtIndex != '0 ? registers[mgmtIndex] : '0;

endmodule

// ==== verilog/programCounter.sv ====
module programCounter
	import rv32Pkg::*;
#(
	parameter dataWord resetAddress = '0
)
(
	input logic clk,
	input logic rst,
	input mgmtRequest mgmt,
	input coreState state,
	input decodedInstr instr,
	input dataWord rs1Value,
	input logic takeBranch,
	input logic advance,
	output dataWord pc,
	output dataWord link,
	output logic jumpMisaligned
);

	logic mgmtPcWrite;
	logic isJump;
	dataWord targetBase;
	dataWord target;
	dataWord nextPc;
	dataWord mgmtJumpTarget;

	assign mgmtPcWrite = !mgmt.run && mgmt.writeEnable && state == stateHalt
		&& mgmtIsPc(mgmt.address);

	assign link = pc + 32'd4;

	// The decoder already picked the J, I or B immediate for the class
	assign targetBase = instr.kind == classJalr ? rs1Value : pc;
	assign target = targetBase + instr.imm;
	assign isJump = instr.kind == classJal || instr.kind == classJalr
		|| (instr.kind == classBranch && takeBranch);
	assign nextPc = isJump ? {target[31:1], 1'b0} : link;
	assign jumpMisaligned = isJump && target[1];

	assign mgmtJumpTarget = pc + mgmt.writeData;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= resetAddress;
		else if (advance)
			pc <= nextPc;
		else if (mgmtPcWrite && mgmt.address[3:0] == mgmtPcSet)
			pc <= {mgmt.writeData[31:1], 1'b0};
		else if (mgmtPcWrite && mgmt.address[3:0] == mgmtPcJump)
			pc <= {mgmtJumpTarget[31:1], 1'b0};
	end

endmodule

// ==== verilog/coreControl.sv ====
module coreControl
	import rv32Pkg::*;
(
	input logic clk,
	input logic rst,
	input mgmtRequest mgmt,
	input decodedInstr instr,
	input logic accessDone,
	input logic misaligned,
	input logic jumpMisaligned,
	input dataWord pc,
	input dataWord raw,
	input dataWord mgmtValue,
	output coreState state,
	output errorCode error,
	output memPhase phase,
	output logic loadInstruction,
	output logic writeBack,
	output logic advance,
	output dataWord mgmtReadData
);

	logic mgmtWrite;
	logic mgmtRead;
	logic stepWrite;
	logic clearErrorWrite;
	logic isMemoryOp;
	logic invalid;
	logic fault;
	logic complete;
	logic writesRd;
	dataWord readValue;

	assign mgmtWrite = !mgmt.run && mgmt.writeEnable && state == stateHalt;
	assign mgmtRead = !mgmt.run && !mgmt.writeEnable;
	assign stepWrite = mgmtWrite && mgmtIsPc(mgmt.address) && mgmt.address[3:0] == mgmtPcStep;
	assign clearErrorWrite = mgmtWrite && mgmtIsClearError(mgmt.address);

	assign isMemoryOp = instr.kind == classLoad || instr.kind == classStore;
	assign invalid = instr.kind == classInvalid;
	assign fault = invalid || misaligned || jumpMisaligned;
	// Loads and stores wait for the memory, everything else takes one cycle
	assign complete = !isMemoryOp || accessDone;
	assign writesRd = instr.kind inside {classLui, classAuipc, classJal, classJalr,
		classLoad, classAluImm, classAlu};

	always_comb begin
		phase = phaseIdle;
		if (state == stateFetch)
			phase = phaseFetch;
		else if (state == stateExecute && instr.kind == classLoad)
			phase = phaseLoad;
		else if (state == stateExecute && instr.kind == classStore)
			phase = phaseStore;
	end

	assign loadInstruction = state == stateFetch && accessDone;
	assign advance = state == stateExecute && !fault && complete;
	assign writeBack = advance && writesRd && instr.rd != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
			error <= '0;
		end else begin
			case (state)
				stateHalt: begin
					if ((mgmt.run || stepWrite) && error == '0)
						state <= stateFetch;
					else if (clearErrorWrite)
						error <= '0;
				end
				stateFetch: begin
					if (misaligned) begin
						error <= 2'b10;
						state <= stateHalt;
					end else if (accessDone) begin
						state <= stateExecute;
					end
				end
				stateExecute: begin
					if (fault) begin
						error <= {misaligned || jumpMisaligned, invalid};
						state <= stateHalt;
					end else if (complete) begin
						state <= mgmt.run ? stateFetch : stateHalt;
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

	// Management read back
	always_comb begin
		readValue = '0;
		if (mgmtRead) begin
			if (mgmtIsPc(mgmt.address))
				readValue = pc;
			else if (mgmtIsInstruction(mgmt.address))
				readValue = raw;
			else if (mgmtIsRegister(mgmt.address))
				readValue = mgmtValue;
		end
	end

	assign mgmtReadData = maskBytes(readValue, mgmt.byteSelect);

endmodule

// ==== verilog/loadStoreUnit.sv ====
module loadStoreUnit
	import rv32Pkg::*;
(
	input memPhase phase,
	input dataWord pc,
	input dataWord sum,
	input logic [2:0] funct3,
	input dataWord rs2Value,
	input dataWord memoryDataRead,
	input logic memoryBusy,
	output memRequest memoryRequest,
	output dataWord loadData,
	output logic accessDone,
	output logic misaligned
);

	dataWord address;
	byteMask baseMask;
	logic [6:0] shiftedMask;
	logic active;
	logic [4:0] laneShift;
	dataWord laneData;
	logic signBit;

	assign address = phase == phaseFetch ? pc : sum;

	always_comb begin
		baseMask = 4'b0000;
		if (phase == phaseFetch) begin
			baseMask = 4'b1111;
		end else if (phase == phaseLoad || phase == phaseStore) begin
			case (funct3[1:0])
				2'b00: baseMask = 4'b0001;
				2'b01: baseMask = 4'b0011;
				2'b10: baseMask = 4'b1111;
				default: baseMask = 4'b0000;
			endcase
		end
	end

	// Lanes pushed past bit 3 cross the word boundary
	assign shiftedMask = {3'b000, baseMask} << address[1:0];
	assign misaligned = |shiftedMask[6:4];
	assign active = phase != phaseIdle && !misaligned;
	assign laneShift = {address[1:0], 3'b000};

	always_comb begin
		memoryRequest = '0;
		if (active) begin
			memoryRequest.address = {address[31:2], 2'b00};
			memoryRequest.byteSelect = shiftedMask[3:0];
			memoryRequest.readEnable = phase != phaseStore;
			if (phase == phaseStore) begin
				memoryRequest.writeEnable = 1'b1;
				memoryRequest.writeData = maskBytes(rs2Value << laneShift, shiftedMask[3:0]);
			end
		end
	end

	assign accessDone = (memoryRequest.readEnable || memoryRequest.writeEnable) && !memoryBusy;

	// Bring the addressed lane down to bit 0
	assign laneData = memoryDataRead >> laneShift;
	assign signBit = !funct3[2] && (funct3[0] ? laneData[15] : laneData[7]);

	always_comb begin
		case (funct3[1:0])
			2'b00: loadData = {{24{signBit}}, laneData[7:0]};
			2'b01: loadData = {{16{signBit}}, laneData[15:0]};
			default: loadData = memoryDataRead;
		endcase
		// Instruction fetch ignores funct3 of the previous instruction
		if (phase == phaseFetch)
			loadData = memoryDataRead;
	end

endmodule

// ==== execute/instructionDecode.sv ====
module instructionDecode
	import rv32Pkg::*;
(
	input logic clk,
	input logic rst,
	input logic loadInstruction,
	input dataWord fetchData,
	output decodedInstr instr,
	output dataWord raw
);

	dataWord ir;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic shiftImmValid;
	instrClass kind;
	dataWord immI;
	dataWord immS;
	dataWord immB;
	dataWord immU;
	dataWord immJ;

	always_ff @(posedge clk) begin
		if (rst)
			ir <= '0;
		else if (loadInstruction)
			ir <= fetchData;
	end

	assign raw = ir;
	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	assign immI = {{20{ir[31]}}, ir[31:20]};
	assign immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign immU = {ir[31:12], 12'h000};
	assign immJ = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	// Immediate shifts only allow SRAI as the alternate form
	assign shiftImmValid = funct3 == 3'b001 ? funct7 == 7'b0000000
		: funct3 == 3'b101 ? (funct7 == 7'b0000000 || funct7 == 7'b0100000)
		: 1'b1;

	// Anything unmatched, system opcodes and compressed forms included, is invalid
	always_comb begin
		kind = classInvalid;
		case (opcode)
			opLui: kind = classLui;
			opAuipc: kind = classAuipc;
			opJal: kind = classJal;
			opJalr: if (funct3 == 3'b000) kind = classJalr;
			opBranch: if (funct3[2:1] != 2'b01) kind = classBranch;
			opLoad: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) kind = classLoad;
			opStore: if (!funct3[2] && funct3[1:0] != 2'b11) kind = classStore;
			opAluImm: if (shiftImmValid) kind = classAluImm;
			opAlu: begin
				if (funct7 == 7'b0000000
					|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					kind = classAlu;
			end
			opFence: if (funct3 == 3'b000) kind = classFence;
			default: kind = classInvalid;
		endcase
	end

	always_comb begin
		instr.kind = kind;
		instr.rd = ir[11:7];
		instr.rs1 = ir[19:15];
		instr.rs2 = ir[24:20];
		instr.funct3 = funct3;
		// Subtract or arithmetic right shift
		instr.alt = funct7 == 7'b0100000
			&& (kind == classAlu || (kind == classAluImm && funct3 == 3'b101));
		case (kind)
			classStore: instr.imm = immS;
			classBranch: instr.imm = immB;
			classLui, classAuipc: instr.imm = immU;
			classJal: instr.imm = immJ;
			default: instr.imm = immI;
		endcase
	end

endmodule

// ==== execute/alu.sv ====
module alu
	import rv32Pkg::*;
(
	input decodedInstr instr,
	input dataWord pc,
	input dataWord rs1Value,
	input dataWord rs2Value,
	input dataWord link,
	input dataWord loadData,
	output dataWord sum,
	output dataWord writeData,
	output logic takeBranch
);

	dataWord inputA;
	dataWord inputB;
	logic [32:0] difference;
	logic equal;
	logic lessThan;
	logic lessThanUnsigned;
	logic isLeftShift;
	dataWord shiftIn;
	logic signed [32:0] shiftExtended;
	logic [32:0] shifted;
	dataWord aluValue;

	function automatic dataWord reverseBits(input dataWord value);
		dataWord reversed;
		for (int i = 0; i < 32; i++)
			reversed[i] = value[31 - i];
		return reversed;
	endfunction

	assign inputA = instr.kind == classAuipc ? pc : rs1Value;
	assign inputB = instr.kind inside {classAuipc, classAluImm, classLoad, classStore}
		? instr.imm : rs2Value;

	assign sum = inputA + inputB;
	assign difference = {1'b0, inputA} - {1'b0, inputB};
	assign equal = difference[31:0] == '0;
	assign lessThan = inputA[31] ^ inputB[31] ? inputA[31] : difference[32];
	assign lessThanUnsigned = difference[32];

	// Left shifts run through the right shifter on reversed bits
	assign isLeftShift = instr.funct3 == 3'b001;
	assign shiftIn = isLeftShift ? reverseBits(inputA) : inputA;
	assign shiftExtended = {instr.alt && !isLeftShift && shiftIn[31], shiftIn};
	assign shifted = shiftExtended >>> inputB[4:0];

	always_comb begin
		case (instr.funct3)
			3'b000: aluValue = instr.alt ? difference[31:0] : sum;
			3'b001: aluValue = reverseBits(shifted[31:0]);
			3'b010: aluValue = {31'b0, lessThan};
			3'b011: aluValue = {31'b0, lessThanUnsigned};
			3'b100: aluValue = inputA ^ inputB;
			3'b101: aluValue = shifted[31:0];
			3'b110: aluValue = inputA | inputB;
			default: aluValue = inputA & inputB;
		endcase
	end

	always_comb begin
		takeBranch = 1'b0;
		if (instr.kind == classBranch) begin
			case (instr.funct3)
				3'b000: takeBranch = equal;
				3'b001: takeBranch = !equal;
				3'b100: takeBranch = lessThan;
				3'b101: takeBranch = !lessThan;
				3'b110: takeBranch = lessThanUnsigned;
				3'b111: takeBranch = !lessThanUnsigned;
				default: takeBranch = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (instr.kind)
			classLui: writeData = instr.imm;
			classAuipc: writeData = sum;
			classJal, classJalr: writeData = link;
			classLoad: writeData = loadData;
			classAluImm, classAlu: writeData = aluValue;
			default: writeData = '0;
		endcase
	end

endmodule

// ==== verilog/rv32iCore.sv ====
module rv32iCore
	import rv32Pkg::*;
#(
	parameter dataWord resetAddress = '0
)
(
	input logic clk,
	input logic rst,
	input mgmtRequest mgmt,
	output dataWord mgmtReadData,
	output memRequest memoryRequest,
	input dataWord memoryDataRead,
	input logic memoryBusy,
	output coreState state,
	output errorCode error
);

	memPhase phase;
	logic loadInstruction;
	logic writeBack;
	logic advance;
	decodedInstr instr;
	dataWord raw;
	dataWord pc;
	dataWord link;
	logic jumpMisaligned;
	dataWord rs1Value;
	dataWord rs2Value;
	dataWord mgmtValue;
	dataWord sum;
	dataWord writeData;
	logic takeBranch;
	dataWord loadData;
	logic accessDone;
	logic misaligned;

	coreControl control (
		.clk(clk),
		.rst(rst),
		.mgmt(mgmt),
		.instr(instr),
		.accessDone(accessDone),
		.misaligned(misaligned),
		.jumpMisaligned(jumpMisaligned),
		.pc(pc),
		.raw(raw),
		.mgmtValue(mgmtValue),
		.state(state),
		.error(error),
		.phase(phase),
		.loadInstruction(loadInstruction),
		.writeBack(writeBack),
		.advance(advance),
		.mgmtReadData(mgmtReadData)
	);

	programCounter #(
		.resetAddress(resetAddress)
	) programCount (
		.clk(clk),
		.rst(rst),
		.mgmt(mgmt),
		.state(state),
		.instr(instr),
		.rs1Value(rs1Value),
		.takeBranch(takeBranch),
		.advance(advance),
		.pc(pc),
		.link(link),
		.jumpMisaligned(jumpMisaligned)
	);

	registerFile registers (
		.clk(clk),
		.mgmt(mgmt),
		.state(state),
		.instr(instr),
		.writeBack(writeBack),
		.writeData(writeData),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.mgmtValue(mgmtValue)
	);

	instructionDecode decode (
		.clk(clk),
		.rst(rst),
		.loadInstruction(loadInstruction),
		.fetchData(loadData),
		.instr(instr),
		.raw(raw)
	);

	alu execute (
		.instr(instr),
		.pc(pc),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.link(link),
		.loadData(loadData),
		.sum(sum),
		.writeData(writeData),
		.takeBranch(takeBranch)
	);

	loadStoreUnit memoryAccess (
		.phase(phase),
		.pc(pc),
		.sum(sum),
		.funct3(instr.funct3),
		.rs2Value(rs2Value),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.memoryRequest(memoryRequest),
		.loadData(loadData),
		.accessDone(accessDone),
		.misaligned(misaligned)
	);

endmodule

// ==== testbench/clockGen.sv ====
module clockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held for 16 rising edges
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

// ==== testbench/coreModel.sv ====
package coreModel;

	logic [31:0] regs [0:31];
	logic [31:0] pc;
	logic [31:0] mem [0:1023];
	logic [1:0] err;

	function automatic logic [31:0] aluCompute(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// Executes the instruction at pc, or records an error and changes nothing
	function automatic void stepOnce();
		logic [31:0] ir;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immU;
		logic [31:0] immJ;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] target;
		logic [31:0] nextPc;
		logic [31:0] w;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [4:0] rd;
		logic writes;
		logic bad;
		logic fault;
		logic take;
		logic isStore;
		int lane;
		ir = mem[pc[11:2]];
		f3 = ir[14:12];
		f7 = ir[31:25];
		rd = ir[11:7];
		immI = {{20{ir[31]}}, ir[31:20]};
		immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
		immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
		immU = {ir[31:12], 12'h000};
		immJ = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
		a = regs[ir[19:15]];
		b = regs[ir[24:20]];
		nextPc = pc + 4;
		res = '0;
		addr = '0;
		writes = 1'b0;
		bad = 1'b0;
		fault = 1'b0;
		take = 1'b0;
		isStore = 1'b0;
		case (ir[6:0])
			7'b0110111: begin
				res = immU;
				writes = 1'b1;
			end
			7'b0010111: begin
				res = pc + immU;
				writes = 1'b1;
			end
			7'b1101111: begin
				target = pc + immJ;
				res = pc + 4;
				writes = 1'b1;
				nextPc = target;
				fault = target[1];
			end
			7'b1100111: begin
				bad = f3 != 3'd0;
				target = a + immI;
				res = pc + 4;
				writes = 1'b1;
				nextPc = {target[31:1], 1'b0};
				fault = target[1];
			end
			7'b1100011: begin
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					3'd7: take = a >= b;
					default: bad = 1'b1;
				endcase
				if (take) begin
					target = pc + immB;
					nextPc = target;
					fault = target[1];
				end
			end
			7'b0000011: begin
				addr = a + immI;
				bad = f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7;
				// Only bytes that spill into the next word fault
				fault = (f3[1:0] == 2'd1 && addr[1:0] == 2'd3)
					|| (f3[1:0] == 2'd2 && addr[1:0] != 2'd0);
				w = mem[addr[11:2]] >> (8 * addr[1:0]);
				case (f3)
					3'd0: res = {{24{w[7]}}, w[7:0]};
					3'd1: res = {{16{w[15]}}, w[15:0]};
					3'd4: res = {24'b0, w[7:0]};
					3'd5: res = {16'b0, w[15:0]};
					default: res = w;
				endcase
				writes = 1'b1;
			end
			7'b0100011: begin
				addr = a + immS;
				bad = f3 > 3'd2;
				fault = (f3 == 3'd1 && addr[1:0] == 2'd3) || (f3 == 3'd2 && addr[1:0] != 2'd0);
				isStore = 1'b1;
			end
			7'b0010011: begin
				if (f3 == 3'd1)
					bad = f7 != 7'h00;
				else if (f3 == 3'd5)
					bad = f7 != 7'h00 && f7 != 7'h20;
				res = aluCompute(f3, f3 == 3'd5 && f7 == 7'h20, a, immI);
				writes = 1'b1;
			end
			7'b0110011: begin
				bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				res = aluCompute(f3, f7 == 7'h20, a, b);
				writes = 1'b1;
			end
			7'b0001111: bad = f3 != 3'd0;
			default: bad = 1'b1;
		endcase
		if (bad) begin
			err = 2'd1;
		end else if (fault) begin
			err = 2'd2;
		end else begin
			if (isStore) begin
				for (int i = 0; i < (1 << f3); i++) begin
					lane = addr[1:0] + i;
					mem[addr[11:2]][8 * lane +: 8] = b[8 * i +: 8];
				end
			end
			if (writes && rd != 5'd0)
				regs[rd] = res;
			pc = nextPc;
		end
	endfunction

	function automatic void runUntilError(input int limit);
		for (int n = 0; n < limit && err == 2'd0; n++)
			stepOnce();
	endfunction

endpackage

// ==== testbench/coreTb.sv ====
module coreTb
	import rv32Pkg::*;
();

	localparam dataWord haltInstr = 32'h0000_0073;

	logic clk;
	logic rst;
	mgmtRequest mgmt;
	dataWord mgmtReadData;
	memRequest memoryRequest;
	dataWord memoryDataRead;
	logic memoryBusy;
	coreState state;
	errorCode error;
	dataWord memory [0:1023];
	integer seed;
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;

	clockGen clocks (
		.clk(clk),
		.rst(rst)
	);

	rv32iCore uut (
		.clk(clk),
		.rst(rst),
		.mgmt(mgmt),
		.mgmtReadData(mgmtReadData),
		.memoryRequest(memoryRequest),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.state(state),
		.error(error)
	);

	// Memory answers in the cycle busy is low
	assign memoryDataRead = memory[memoryRequest.address[11:2]];

	always @(posedge clk) begin
		if (memoryRequest.writeEnable && !memoryBusy)
			for (int i = 0; i < 4; i++)
				if (memoryRequest.byteSelect[i])
					memory[memoryRequest.address[11:2]][8 * i +: 8] <=
						memoryRequest.writeData[8 * i +: 8];
		#1;
		memoryBusy = ($random(seed) & 3) == 0;
	end

	function automatic int pick(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic dataWord keepLanes(input dataWord value, input byteMask sel);
		return value & {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	function automatic dataWord encR(input logic [6:0] f7, input regIndex rs2, input regIndex rs1,
		input logic [2:0] f3, input regIndex rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic dataWord encI(input logic [11:0] imm, input regIndex rs1,
		input logic [2:0] f3, input regIndex rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic dataWord encS(input logic [11:0] imm, input regIndex rs2,
		input regIndex rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic dataWord encB(input logic [12:0] imm, input regIndex rs2,
		input regIndex rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic dataWord encJ(input logic [20:0] imm, input regIndex rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic dataWord randomAluInstr();
		logic [2:0] f3;
		logic [6:0] f7;
		regIndex rd;
		regIndex rs1;
		regIndex rs2;
		int kind;
		kind = pick(5);
		f3 = pick(8);
		rd = pick(32);
		rs1 = pick(32);
		rs2 = pick(32);
		f7 = (f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1 ? 7'h20 : 7'h00;
		case (kind)
			0: return {20'($random(seed)), rd, 7'b0110111};
			1: return {20'($random(seed)), rd, 7'b0010111};
			2, 3: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					return encI({f7, rs2}, rs1, f3, rd, 7'b0010011);
				return encI(12'($random(seed)), rs1, f3, rd, 7'b0010011);
			end
			default: return encR(f7, rs2, rs1, f3, rd);
		endcase
	endfunction

	task automatic compareWord(input string name, input dataWord expected, input dataWord actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic compareState(input string name, input coreState expected,
		input coreState actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("FAIL %s expected %s actual %s", name, expected.name(), actual.name());
		end
	endtask

	task automatic compareError(input string name, input errorCode expected,
		input errorCode actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic putWord(input dataWord address, input dataWord value);
		memory[address[11:2]] = value;
		coreModel::mem[address[11:2]] = value;
	endtask

	task automatic mgmtWrite(input logic [15:0] address, input dataWord data);
		@(posedge clk);
		#1;
		mgmt.address = address;
		mgmt.writeData = data;
		mgmt.byteSelect = 4'hf;
		mgmt.writeEnable = 1'b1;
		@(posedge clk);
		#1;
		mgmt.writeEnable = 1'b0;
	endtask

	task automatic mgmtRead(input logic [15:0] address, input byteMask sel, output dataWord data);
		@(posedge clk);
		#1;
		mgmt.address = address;
		mgmt.byteSelect = sel;
		#2;
		data = mgmtReadData;
	endtask

	task automatic setRegister(input int index, input dataWord value);
		mgmtWrite(16'h4000 + 16'(index * 4), value);
		if (index != 0)
			coreModel::regs[index] = value;
	endtask

	task automatic setPc(input dataWord value);
		mgmtWrite(16'h0000, value);
		coreModel::pc = value;
	endtask

	task automatic waitForHalt(input int limit);
		int n;
		n = 0;
		while (state != stateHalt && n < limit) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (state != stateHalt) begin
			$display("Timeout: the core never returned to halt");
			$display("Something failed");
			$finish;
		end
	endtask

	task automatic runProgram();
		int n;
		n = 0;
		@(posedge clk);
		#1;
		mgmt.run = 1'b1;
		while (state == stateHalt && n < 50) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (state == stateHalt) begin
			$display("Timeout: the core never left halt after run was raised");
			$display("Something failed");
			$finish;
		end
		waitForHalt(200000);
		@(posedge clk);
		#1;
		mgmt.run = 1'b0;
		coreModel::runUntilError(10000);
	endtask

	task automatic stepCore();
		mgmtWrite(16'h0008, '0);
		waitForHalt(10000);
		coreModel::stepOnce();
	endtask

	task automatic clearError(input string name);
		compareError(name, coreModel::err, error);
		compareState(name, stateHalt, state);
		mgmtWrite(16'h0020, '0);
		coreModel::err = 2'd0;
	endtask

	task automatic checkRegisters(input string name);
		dataWord got;
		for (int i = 1; i < 32; i++) begin
			mgmtRead(16'h4000 + 16'(i * 4), 4'hf, got);
			compareWord($sformatf("%s x%0d", name, i), coreModel::regs[i], got);
		end
		mgmtRead(16'h0000, 4'hf, got);
		compareWord({name, " pc"}, coreModel::pc, got);
	endtask

	task automatic checkDataWords(input string name);
		for (int i = 512; i < 576; i++)
			compareWord($sformatf("%s mem[%0d]", name, i), coreModel::mem[i], memory[i]);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("%-24s passed", name);
		end else begin
			failedTests++;
			$display("%-24s had %0d mismatches", name, errorCount - errorsBefore);
		end
	endtask

	initial begin
		int start;
		int off;
		int kind;
		logic [2:0] f3;
		dataWord value;
		dataWord got;
		byteMask sel;
		dataWord branchValues [4];
		seed = 32'h3e79_89c8;
		mgmt = '0;
		memoryBusy = 1'b0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		branchValues = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
		for (int i = 0; i < 1024; i++)
			putWord(32'(i * 4), 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f);
		for (int i = 0; i < 32; i++)
			coreModel::regs[i] = '0;
		coreModel::pc = '0;
		coreModel::err = 2'd0;
		repeat (20) @(posedge clk);

		start = errorCount;
		for (int i = 0; i < 32; i++)
			setRegister(i, $random(seed));
		for (int i = 0; i < 32; i++) begin
			sel = pick(16);
			mgmtRead(16'h4000 + 16'(i * 4), sel, got);
			compareWord($sformatf("readback x%0d", i), keepLanes(coreModel::regs[i], sel), got);
		end
		value = $random(seed) & ~32'd3;
		setPc(value);
		sel = pick(16);
		mgmtRead(16'h0000, sel, got);
		compareWord("readback pc", keepLanes(value, sel), got);
		finishTest("management readback", start);

		start = errorCount;
		for (int i = 0; i < 200; i++)
			putWord(32'(i * 4), randomAluInstr());
		putWord(32'd800, haltInstr);
		setPc('0);
		runProgram();
		clearError("alu program");
		checkRegisters("alu program");
		finishTest("alu program", start);

		start = errorCount;
		for (int i = 0; i < 40; i++) begin
			if (pick(2) == 1) begin
				f3 = pick(3);
				off = pick(64) * 4 + (f3 == 3'd0 ? pick(4) : f3 == 3'd1 ? pick(2) * 2 : 0);
				putWord(32'(i * 4), encS(off, pick(30) + 2, 5'd1, f3));
			end else begin
				kind = pick(5);
				f3 = kind == 3 ? 3'd4 : kind == 4 ? 3'd5 : 3'(kind);
				off = pick(64) * 4 + (f3[1:0] == 2'd0 ? pick(4) : f3[1:0] == 2'd1 ? pick(2) * 2 : 0);
				putWord(32'(i * 4), encI(off, 5'd1, f3, pick(30) + 2, 7'b0000011));
			end
		end
		putWord(32'd160, haltInstr);
		setRegister(1, 32'h800);
		for (int i = 2; i < 32; i++)
			setRegister(i, $random(seed));
		setPc('0);
		runProgram();
		clearError("load store");
		checkRegisters("load store");
		checkDataWords("load store");
		for (int s = 1; s < 3; s++) begin
			off = pick(64) * 4 + (s == 1 ? 3 : 1 + pick(3));
			putWord('0, encS(off, pick(30) + 2, 5'd1, 3'(s)));
			putWord(32'd4, haltInstr);
			setPc('0);
			runProgram();
			clearError($sformatf("misaligned store %0d", s));
			checkDataWords("misaligned store");
			off = pick(64) * 4 + (s == 1 ? 3 : 1 + pick(3));
			putWord('0, encI(off, 5'd1, 3'(s), 5'd2, 7'b0000011));
			setPc('0);
			runProgram();
			clearError($sformatf("misaligned load %0d", s));
			checkRegisters("misaligned load");
		end
		finishTest("load store", start);

		start = errorCount;
		for (int i = 2; i < 10; i++)
			setRegister(i, branchValues[pick(4)]);
		setRegister(10, '0);
		off = 0;
		for (int k = 0; k < 20; k++) begin
			kind = pick(3);
			if (kind == 0) begin
				f3 = pick(6);
				f3 = f3 < 3'd2 ? f3 : f3 + 3'd2;
				putWord(32'(off), encB(13'd8, pick(8) + 2, pick(8) + 2, f3));
			end else if (kind == 1) begin
				putWord(32'(off), encJ(21'd8, 11 + k % 10));
			end else begin
				putWord(32'(off), {20'd0, 5'd21, 7'b0010111});
				off += 4;
				putWord(32'(off), encI(12'd12, 5'd21, 3'd0, 11 + k % 10, 7'b1100111));
			end
			putWord(32'(off + 4), encI(12'd1, 5'd10, 3'd0, 5'd10, 7'b0010011));
			off += 8;
		end
		putWord(32'(off), haltInstr);
		setPc('0);
		runProgram();
		clearError("branch jump");
		checkRegisters("branch jump");
		putWord('0, encJ(21'd6, 5'd11));
		putWord(32'd4, haltInstr);
		setPc('0);
		runProgram();
		clearError("misaligned jump");
		checkRegisters("misaligned jump");
		finishTest("branch jump", start);

		start = errorCount;
		for (int i = 0; i < 3; i++)
			putWord(32'(i * 4), randomAluInstr());
		putWord(32'd12, haltInstr);
		setPc('0);
		for (int i = 0; i < 3; i++) begin
			stepCore();
			compareError("single step", coreModel::err, error);
			checkRegisters($sformatf("single step %0d", i));
			compareState("single step", stateHalt, state);
		end
		stepCore();
		compareError("step invalid", 2'd1, error);
		clearError("step invalid");
		compareError("error cleared", 2'd0, error);
		checkRegisters("step invalid");
		finishTest("single step", start);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== project.f ====
common/rv32Pkg.sv
verilog/registerFile.sv
verilog/programCounter.sv
verilog/coreControl.sv
verilog/loadStoreUnit.sv
execute/instructionDecode.sv
execute/alu.sv
verilog/rv32iCore.sv
testbench/clockGen.sv
testbench/coreModel.sv
testbench/coreTb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - common/rv32Pkg.sv
  - verilog/registerFile.sv
  - verilog/programCounter.sv
  - verilog/coreControl.sv
  - verilog/loadStoreUnit.sv
  - execute/instructionDecode.sv
  - execute/alu.sv
  - verilog/rv32iCore.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/coreModel.sv
      - testbench/coreTb.sv
